//--- hdl/cache_pkg.sv
`default_nettype none

package cache_pkg;

   // front-end word and address
   localparam int addr_w     = 32;
   localparam int data_w     = 32;
   localparam int nbytes     = data_w / 8;
   localparam int byte_off_w = $clog2(nbytes);

   // cache geometry
   localparam int word_off_w    = 2;
   localparam int line_off_w    = 6;
   localparam int tag_w         = addr_w - line_off_w - word_off_w - byte_off_w;
   localparam int wtbuf_depth_w = 2;

   // axi constants
   localparam int                  axi_id_w  = 1;
   localparam logic [axi_id_w-1:0] axi_id    = '0;
   localparam int                  burst_len = (1 << word_off_w) - 1;

   typedef logic [addr_w-1:0]              addr_t;
   typedef logic [addr_w-byte_off_w-1:0]   word_addr_t;
   typedef logic [tag_w+line_off_w-1:0]    line_addr_t;
   typedef logic [data_w-1:0]              data_t;
   typedef logic [nbytes-1:0]              strb_t;
   typedef logic [tag_w-1:0]               tag_t;
   typedef logic [line_off_w-1:0]          line_idx_t;
   typedef logic [word_off_w-1:0]          word_off_t;

   typedef enum logic [2:0] {
      idle,
      lookup,
      wait_drain,
      fill,
      respond
   } cache_state_t;

   typedef enum logic [1:0] {
      rd_idle,
      rd_addr,
      rd_data
   } rd_state_t;

   typedef enum logic [1:0] {
      wr_idle,
      wr_req,
      wr_resp
   } wr_state_t;

endpackage

`default_nettype wire

//--- hdl/cache_memory.sv
`timescale 1ns/100ps
`default_nettype none

module cache_memory
(
   input  logic                  clk,
   input  logic                  rst_n,
   // front port
   input  logic                  valid,
   input  cache_pkg::addr_t      addr,
   input  cache_pkg::data_t      wdata,
   input  cache_pkg::strb_t      wstrb,
   output cache_pkg::data_t      rdata,
   output logic                  ready,
   // write-through buffer
   input  logic                  full,
   input  logic                  empty,
   output logic                  push,
   output cache_pkg::word_addr_t push_addr,
   output cache_pkg::data_t      push_wdata,
   output cache_pkg::strb_t      push_wstrb,
   // line replacement
   output logic                  replace_valid,
   output cache_pkg::line_addr_t replace_addr,
   input  logic                  replace_ready,
   input  logic                  read_valid,
   input  cache_pkg::word_off_t  read_addr,
   input  cache_pkg::data_t      read_rdata
);

   cache_pkg::cache_state_t state;
   cache_pkg::cache_state_t state_nxt;

   // stored request
   cache_pkg::word_addr_t req_addr;
   cache_pkg::data_t      req_wdata;
   cache_pkg::strb_t      req_wstrb;
   cache_pkg::tag_t       req_tag;
   cache_pkg::line_idx_t  req_idx;
   cache_pkg::word_off_t  req_off;
   logic                  req_write;
   logic                  hit;
   logic                  fill_done;

   // one way of 64 lines by 4 words
   cache_pkg::data_t data_mem [2**cache_pkg::line_off_w][2**cache_pkg::word_off_w];
   cache_pkg::tag_t  tag_mem [2**cache_pkg::line_off_w];
   logic [2**cache_pkg::line_off_w-1:0] line_valid;

   assign req_off   = req_addr[cache_pkg::word_off_w-1:0];
   assign req_idx   = req_addr[cache_pkg::word_off_w +: cache_pkg::line_off_w];
   assign req_tag   = req_addr[cache_pkg::addr_w-cache_pkg::byte_off_w-1 -: cache_pkg::tag_w];
   assign req_write = |req_wstrb;

   // tags are stable from lookup to respond, so hit holds for a write
   assign hit       = line_valid[req_idx] && (tag_mem[req_idx] == req_tag);
   assign fill_done = (state == cache_pkg::fill) && replace_ready;

   always_ff @(posedge clk)
   begin
      if (state == cache_pkg::idle && valid)
      begin
         req_addr  <= addr[cache_pkg::addr_w-1:cache_pkg::byte_off_w];
         req_wdata <= wdata;
         req_wstrb <= wstrb;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= cache_pkg::idle;
      else
         state <= state_nxt;
   end

   always_comb
   begin
      state_nxt = state;
      case (state)
         cache_pkg::idle:
            if (valid)
               state_nxt = cache_pkg::lookup;
         cache_pkg::lookup:
            if (req_write)
            begin
               // wait here while the buffer is full
               if (!full)
                  state_nxt = cache_pkg::respond;
            end
            else if (hit)
               state_nxt = cache_pkg::idle;
            else
               state_nxt = cache_pkg::wait_drain;
         cache_pkg::wait_drain:
            // memory must see every pending write before the fill
            if (empty)
               state_nxt = cache_pkg::fill;
         cache_pkg::fill:
            if (replace_ready)
               state_nxt = cache_pkg::respond;
         cache_pkg::respond:
            state_nxt = cache_pkg::idle;
         default:
            state_nxt = cache_pkg::idle;
      endcase
   end

   // valid bits
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         line_valid <= '0;
      else if (fill_done)
         line_valid[req_idx] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (fill_done)
         tag_mem[req_idx] <= req_tag;
   end

   // fill beats, or byte merge of a write hit
   always_ff @(posedge clk)
   begin
      if (state == cache_pkg::fill && read_valid)
         data_mem[req_idx][read_addr] <= read_rdata;
      else if (push && hit)
      begin
         for (int i = 0; i < cache_pkg::nbytes; i++)
         begin
            if (req_wstrb[i])
               data_mem[req_idx][req_off][8*i +: 8] <= req_wdata[8*i +: 8];
         end
      end
   end

   // read hit answers in lookup, everything else in respond
   assign ready = (state == cache_pkg::lookup && !req_write && hit) ||
                  (state == cache_pkg::respond);
   assign rdata = data_mem[req_idx][req_off];

   // write-through push in the ready cycle
   assign push       = (state == cache_pkg::respond) && req_write;
   assign push_addr  = req_addr;
   assign push_wdata = req_wdata;
   assign push_wstrb = req_wstrb;

   assign replace_valid = (state == cache_pkg::fill);
   assign replace_addr  = {req_tag, req_idx};

endmodule

`default_nettype wire

//--- hdl/write_through_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module write_through_buffer
(
   input  logic                  clk,
   input  logic                  rst_n,
   // from cache memory
   input  logic                  push,
   input  cache_pkg::word_addr_t push_addr,
   input  cache_pkg::data_t      push_wdata,
   input  cache_pkg::strb_t      push_wstrb,
   output logic                  full,
   output logic                  empty,
   // to back end
   output logic                  write_valid,
   output cache_pkg::word_addr_t write_addr,
   output cache_pkg::data_t      write_wdata,
   output cache_pkg::strb_t      write_wstrb,
   input  logic                  write_ready
);

   cache_pkg::word_addr_t addr_mem [2**cache_pkg::wtbuf_depth_w];
   cache_pkg::data_t      data_mem [2**cache_pkg::wtbuf_depth_w];
   cache_pkg::strb_t      strb_mem [2**cache_pkg::wtbuf_depth_w];

   logic [cache_pkg::wtbuf_depth_w-1:0] wr_ptr;
   logic [cache_pkg::wtbuf_depth_w-1:0] rd_ptr;
   logic [cache_pkg::wtbuf_depth_w:0]   count;
   logic                                wr_en;
   logic                                rd_en;

   assign wr_en = push && !full;
   assign rd_en = write_ready && !empty;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         if (wr_en && !rd_en)
            count <= count + 1'b1;
         else if (rd_en && !wr_en)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         addr_mem[wr_ptr] <= push_addr;
         data_mem[wr_ptr] <= push_wdata;
         strb_mem[wr_ptr] <= push_wstrb;
      end
   end

   // count msb is set only at full depth
   assign full        = count[cache_pkg::wtbuf_depth_w];
   assign empty       = (count == '0);
   assign write_valid = !empty;
   assign write_addr  = addr_mem[rd_ptr];
   assign write_wdata = data_mem[rd_ptr];
   assign write_wstrb = strb_mem[rd_ptr];

endmodule

`default_nettype wire

//--- hdl/back_end_axi.sv
`timescale 1ns/100ps
`default_nettype none

module back_end_axi
(
   input  logic                              clk,
   input  logic                              rst_n,
   // write channel from the buffer
   input  logic                              write_valid,
   input  cache_pkg::word_addr_t             write_addr,
   input  cache_pkg::data_t                  write_wdata,
   input  cache_pkg::strb_t                  write_wstrb,
   output logic                              write_ready,
   // line replacement
   input  logic                              replace_valid,
   input  cache_pkg::line_addr_t             replace_addr,
   output logic                              replace_ready,
   output logic                              read_valid,
   output cache_pkg::word_off_t              read_addr,
   output cache_pkg::data_t                  read_rdata,
   // axi read address
   output logic                              axi_arvalid,
   output cache_pkg::addr_t                  axi_araddr,
   output logic [7:0]                        axi_arlen,
   output logic [2:0]                        axi_arsize,
   output logic [1:0]                        axi_arburst,
   output logic [cache_pkg::axi_id_w-1:0]    axi_arid,
   input  logic                              axi_arready,
   // axi read data
   input  logic                              axi_rvalid,
   input  cache_pkg::data_t                  axi_rdata,
   input  logic [1:0]                        axi_rresp,
   input  logic                              axi_rlast,
   output logic                              axi_rready,
   // axi write address
   output logic                              axi_awvalid,
   output cache_pkg::addr_t                  axi_awaddr,
   output logic [7:0]                        axi_awlen,
   output logic [2:0]                        axi_awsize,
   output logic [1:0]                        axi_awburst,
   output logic [cache_pkg::axi_id_w-1:0]    axi_awid,
   input  logic                              axi_awready,
   // axi write data and response
   output logic                              axi_wvalid,
   output cache_pkg::data_t                  axi_wdata,
   output cache_pkg::strb_t                  axi_wstrb,
   output logic                              axi_wlast,
   input  logic                              axi_wready,
   input  logic                              axi_bvalid,
   input  logic [1:0]                        axi_bresp,
   output logic                              axi_bready
);

   cache_pkg::rd_state_t rd_state;
   cache_pkg::wr_state_t wr_state;
   cache_pkg::word_off_t beat_cnt;
   logic                 aw_done;
   logic                 w_done;
   logic                 aw_hs;
   logic                 w_hs;

   // line fill FSM
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rd_state <= cache_pkg::rd_idle;
         beat_cnt <= '0;
      end
      else
      begin
         case (rd_state)
            cache_pkg::rd_idle:
               if (replace_valid)
               begin
                  rd_state <= cache_pkg::rd_addr;
                  beat_cnt <= '0;
               end
            cache_pkg::rd_addr:
               if (axi_arready)
                  rd_state <= cache_pkg::rd_data;
            cache_pkg::rd_data:
               if (axi_rvalid)
               begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (axi_rlast)
                     rd_state <= cache_pkg::rd_idle;
               end
            default:
               rd_state <= cache_pkg::rd_idle;
         endcase
      end
   end

   // line-aligned INCR burst of one line
   assign axi_arvalid = (rd_state == cache_pkg::rd_addr);
   assign axi_araddr  = {replace_addr, {(cache_pkg::word_off_w+cache_pkg::byte_off_w){1'b0}}};
   assign axi_arlen   = 8'(cache_pkg::burst_len);
   assign axi_arsize  = 3'(cache_pkg::byte_off_w);
   assign axi_arburst = 2'b01;
   assign axi_arid    = cache_pkg::axi_id;
   assign axi_rready  = (rd_state == cache_pkg::rd_data);

   assign read_valid    = axi_rready && axi_rvalid;
   assign read_addr     = beat_cnt;
   assign read_rdata    = axi_rdata;
   assign replace_ready = read_valid && axi_rlast;

   // single-beat write FSM
   assign aw_hs = axi_awvalid && axi_awready;
   assign w_hs  = axi_wvalid && axi_wready;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_state <= cache_pkg::wr_idle;
         aw_done  <= 1'b0;
         w_done   <= 1'b0;
      end
      else
      begin
         case (wr_state)
            cache_pkg::wr_idle:
               if (write_valid)
                  wr_state <= cache_pkg::wr_req;
            cache_pkg::wr_req:
               // AW and W may complete in either order
               if ((aw_done || aw_hs) && (w_done || w_hs))
               begin
                  wr_state <= cache_pkg::wr_resp;
                  aw_done  <= 1'b0;
                  w_done   <= 1'b0;
               end
               else
               begin
                  aw_done <= aw_done || aw_hs;
                  w_done  <= w_done || w_hs;
               end
            cache_pkg::wr_resp:
               if (axi_bvalid)
                  wr_state <= cache_pkg::wr_idle;
            default:
               wr_state <= cache_pkg::wr_idle;
         endcase
      end
   end

   assign axi_awvalid = (wr_state == cache_pkg::wr_req) && !aw_done;
   assign axi_awaddr  = {write_addr, {cache_pkg::byte_off_w{1'b0}}};
   assign axi_awlen   = 8'd0;
   assign axi_awsize  = 3'(cache_pkg::byte_off_w);
   assign axi_awburst = 2'b01;
   assign axi_awid    = cache_pkg::axi_id;

   assign axi_wvalid = (wr_state == cache_pkg::wr_req) && !w_done;
   assign axi_wdata  = write_wdata;
   assign axi_wstrb  = write_wstrb;
   assign axi_wlast  = 1'b1;

   // response pops the buffer head
   assign axi_bready  = (wr_state == cache_pkg::wr_resp);
   assign write_ready = axi_bready && axi_bvalid;

endmodule

`default_nettype wire

//--- hdl/cache_axi.sv
`timescale 1ns/100ps
`default_nettype none

module cache_axi
(
   input  logic                              clk,
   input  logic                              rst_n,
   // front port
   input  logic                              valid,
   input  cache_pkg::addr_t                  addr,
   input  cache_pkg::data_t                  wdata,
   input  cache_pkg::strb_t                  wstrb,
   output cache_pkg::data_t                  rdata,
   output logic                              ready,
   // axi read address
   output logic                              axi_arvalid,
   output cache_pkg::addr_t                  axi_araddr,
   output logic [7:0]                        axi_arlen,
   output logic [2:0]                        axi_arsize,
   output logic [1:0]                        axi_arburst,
   output logic [cache_pkg::axi_id_w-1:0]    axi_arid,
   input  logic                              axi_arready,
   // axi read data
   input  logic                              axi_rvalid,
   input  cache_pkg::data_t                  axi_rdata,
   input  logic [1:0]                        axi_rresp,
   input  logic                              axi_rlast,
   output logic                              axi_rready,
   // axi write address
   output logic                              axi_awvalid,
   output cache_pkg::addr_t                  axi_awaddr,
   output logic [7:0]                        axi_awlen,
   output logic [2:0]                        axi_awsize,
   output logic [1:0]                        axi_awburst,
   output logic [cache_pkg::axi_id_w-1:0]    axi_awid,
   input  logic                              axi_awready,
   // axi write data and response
   output logic                              axi_wvalid,
   output cache_pkg::data_t                  axi_wdata,
   output cache_pkg::strb_t                  axi_wstrb,
   output logic                              axi_wlast,
   input  logic                              axi_wready,
   input  logic                              axi_bvalid,
   input  logic [1:0]                        axi_bresp,
   output logic                              axi_bready
);

   // buffer push side
   logic                  full;
   logic                  empty;
   logic                  push;
   cache_pkg::word_addr_t push_addr;
   cache_pkg::data_t      push_wdata;
   cache_pkg::strb_t      push_wstrb;

   // buffer head to back end
   logic                  write_valid;
   logic                  write_ready;
   cache_pkg::word_addr_t write_addr;
   cache_pkg::data_t      write_wdata;
   cache_pkg::strb_t      write_wstrb;

   // line fill
   logic                  replace_valid;
   logic                  replace_ready;
   cache_pkg::line_addr_t replace_addr;
   logic                  read_valid;
   cache_pkg::word_off_t  read_addr;
   cache_pkg::data_t      read_rdata;

   // all channel names match the block ports
   cache_memory i_cache_memory (.*);

   write_through_buffer i_write_through_buffer (.*);

   back_end_axi i_back_end_axi (.*);

endmodule

`default_nettype wire

//--- testbench/axi_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module axi_mem_model
(
   input  logic             clk,
   // read address and data
   input  logic             axi_arvalid,
   input  cache_pkg::addr_t axi_araddr,
   output logic             axi_arready,
   output logic             axi_rvalid,
   output cache_pkg::data_t axi_rdata,
   output logic [1:0]       axi_rresp,
   output logic             axi_rlast,
   input  logic             axi_rready,
   // write address, data and response
   input  logic             axi_awvalid,
   input  cache_pkg::addr_t axi_awaddr,
   output logic             axi_awready,
   input  logic             axi_wvalid,
   input  cache_pkg::data_t axi_wdata,
   input  cache_pkg::strb_t axi_wstrb,
   output logic             axi_wready,
   output logic             axi_bvalid,
   output logic [1:0]       axi_bresp,
   input  logic             axi_bready
);

   // 4 KiB of words
   cache_pkg::data_t mem [1024];

   logic             ar_hs;
   logic             r_hs;
   logic             aw_hs;
   logic             w_hs;
   logic             b_hs;
   int               ar_gap;
   int               r_gap;
   int               aw_gap;
   int               w_gap;
   int               b_gap;
   int               r_left;
   int               b_pending;
   logic [9:0]       r_idx;
   logic [9:0]       aw_idx_q [$];
   cache_pkg::data_t w_data_q [$];
   cache_pkg::strb_t w_strb_q [$];

   function automatic int rand_gap();
      return int'($urandom_range(0, 3));
   endfunction

   task automatic write_word(input logic [9:0] idx, input cache_pkg::data_t data,
                             input cache_pkg::strb_t strb);
      for (int i = 0; i < cache_pkg::nbytes; i++)
      begin
         if (strb[i])
            mem[idx][8*i +: 8] = data[8*i +: 8];
      end
   endtask

   initial
   begin
      axi_arready = 1'b0;
      axi_rvalid  = 1'b0;
      axi_rdata   = '0;
      axi_rresp   = 2'b00;
      axi_rlast   = 1'b0;
      axi_awready = 1'b0;
      axi_wready  = 1'b0;
      axi_bvalid  = 1'b0;
      axi_bresp   = 2'b00;
      ar_gap      = 0;
      r_gap       = 0;
      aw_gap      = 0;
      w_gap       = 0;
      b_gap       = 0;
      r_left      = 0;
      b_pending   = 0;
      r_idx       = '0;
      // random contents once the generator is seeded
      #1;
      for (int i = 0; i < 1024; i++)
         mem[i] = $urandom;
      forever
      begin
         @(posedge clk);
         // handshakes of the cycle that just ended
         ar_hs = axi_arvalid && axi_arready;
         r_hs  = axi_rvalid && axi_rready;
         aw_hs = axi_awvalid && axi_awready;
         w_hs  = axi_wvalid && axi_wready;
         b_hs  = axi_bvalid && axi_bready;
         if (ar_hs)
         begin
            r_idx  = axi_araddr[11:2];
            r_left = cache_pkg::burst_len + 1;
            ar_gap = rand_gap();
            r_gap  = rand_gap();
         end
         if (r_hs)
         begin
            r_left = r_left - 1;
            r_idx  = r_idx + 10'd1;
            r_gap  = rand_gap();
         end
         if (aw_hs)
         begin
            aw_idx_q.push_back(axi_awaddr[11:2]);
            aw_gap = rand_gap();
         end
         if (w_hs)
         begin
            w_data_q.push_back(axi_wdata);
            w_strb_q.push_back(axi_wstrb);
            w_gap = rand_gap();
         end
         // a write lands once both halves are in
         while (aw_idx_q.size() > 0 && w_data_q.size() > 0)
         begin
            write_word(aw_idx_q.pop_front(), w_data_q.pop_front(), w_strb_q.pop_front());
            b_pending++;
         end
         if (b_hs)
         begin
            b_pending--;
            b_gap = rand_gap();
         end

         #1;
         if (ar_hs || !axi_arvalid)
            axi_arready = 1'b0;
         else if (ar_gap > 0)
            ar_gap--;
         else
            axi_arready = 1'b1;

         if (aw_hs || !axi_awvalid)
            axi_awready = 1'b0;
         else if (aw_gap > 0)
            aw_gap--;
         else
            axi_awready = 1'b1;

         if (w_hs || !axi_wvalid)
            axi_wready = 1'b0;
         else if (w_gap > 0)
            w_gap--;
         else
            axi_wready = 1'b1;

         // next read beat after its gap
         if (r_hs || !axi_rvalid)
         begin
            axi_rvalid = 1'b0;
            axi_rlast  = 1'b0;
            if (r_left > 0)
            begin
               if (r_gap > 0)
                  r_gap--;
               else
               begin
                  axi_rvalid = 1'b1;
                  axi_rdata  = mem[r_idx];
                  axi_rlast  = (r_left == 1);
               end
            end
         end

         if (b_hs || !axi_bvalid)
         begin
            axi_bvalid = 1'b0;
            if (b_pending > 0)
            begin
               if (b_gap > 0)
                  b_gap--;
               else
                  axi_bvalid = 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- testbench/tb_cache_axi.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cache_axi;

   localparam int n_req     = 400;
   localparam int max_cycle = n_req * 60;

   logic                                  clk = 1'b0;
   logic                                  rst_n;
   logic                                  valid;
   cache_pkg::addr_t                      addr;
   cache_pkg::data_t                      wdata;
   cache_pkg::strb_t                      wstrb;
   cache_pkg::data_t                      rdata;
   logic                                  ready;
   logic                                  axi_arvalid;
   cache_pkg::addr_t                      axi_araddr;
   logic [7:0]                            axi_arlen;
   logic [2:0]                            axi_arsize;
   logic [1:0]                            axi_arburst;
   logic [cache_pkg::axi_id_w-1:0]        axi_arid;
   logic                                  axi_arready;
   logic                                  axi_rvalid;
   cache_pkg::data_t                      axi_rdata;
   logic [1:0]                            axi_rresp;
   logic                                  axi_rlast;
   logic                                  axi_rready;
   logic                                  axi_awvalid;
   cache_pkg::addr_t                      axi_awaddr;
   logic [7:0]                            axi_awlen;
   logic [2:0]                            axi_awsize;
   logic [1:0]                            axi_awburst;
   logic [cache_pkg::axi_id_w-1:0]        axi_awid;
   logic                                  axi_awready;
   logic                                  axi_wvalid;
   cache_pkg::data_t                      axi_wdata;
   cache_pkg::strb_t                      axi_wstrb;
   logic                                  axi_wlast;
   logic                                  axi_wready;
   logic                                  axi_bvalid;
   logic [1:0]                            axi_bresp;
   logic                                  axi_bready;

   // reference models
   cache_pkg::data_t shadow [1024];
   logic [7:0]       resident_line [64];
   logic             resident_valid [64];

   // expected writes in request order
   cache_pkg::addr_t exp_addr_q [$];
   cache_pkg::data_t exp_data_q [$];
   cache_pkg::strb_t exp_strb_q [$];
   int               exp_rd = 0;

   // observed AXI traffic
   cache_pkg::addr_t aw_q [$];
   cache_pkg::data_t w_data_q [$];
   cache_pkg::strb_t w_strb_q [$];
   int               ar_count = 0;
   cache_pkg::addr_t last_araddr = '0;
   int               cycle = 0;

   cache_axi i_dut (.*);

   axi_mem_model i_mem (.*);

   always #2 clk = ~clk;

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
      if (actual !== expected)
      begin
         $display("error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
         $display("Testbench failed");
         $fatal(1);
      end
   endtask

   always @(posedge clk)
   begin
      cycle++;
      if (cycle > max_cycle)
      begin
         $display("timeout: the run did not end within %0d cycles", max_cycle);
         $display("Testbench failed");
         $fatal(1);
      end
   end

   // AXI monitor
   always @(posedge clk)
   begin
      if (axi_arvalid && axi_arready)
      begin
         ar_count++;
         last_araddr = axi_araddr;
         check(32'(axi_arlen), 32'd3, "AR length");
         check(32'(axi_arsize), 32'd2, "AR size");
         check(32'(axi_arburst), 32'd1, "AR burst type");
         check(32'(axi_arid), 32'd0, "AR id");
      end
      // read data is never back-pressured by the cache
      if (axi_rvalid)
         check(32'(axi_rready), 32'd1, "R ready during a burst");
      if (axi_awvalid && axi_awready)
      begin
         check(32'(axi_awlen), 32'd0, "AW length");
         check(32'(axi_awsize), 32'd2, "AW size");
         check(32'(axi_awburst), 32'd1, "AW burst type");
         check(32'(axi_awid), 32'd0, "AW id");
         aw_q.push_back(axi_awaddr);
      end
      if (axi_wvalid && axi_wready)
      begin
         check(32'(axi_wlast), 32'd1, "W last");
         w_data_q.push_back(axi_wdata);
         w_strb_q.push_back(axi_wstrb);
      end
      while (aw_q.size() > 0 && w_data_q.size() > 0)
      begin
         check(32'(exp_rd < exp_addr_q.size()), 32'd1, "AXI write with no request pending");
         check(aw_q.pop_front(), exp_addr_q[exp_rd], "write address");
         check(w_data_q.pop_front(), exp_data_q[exp_rd], "write data");
         check(32'(w_strb_q.pop_front()), 32'(exp_strb_q[exp_rd]), "write strobe");
         exp_rd++;
      end
   end

   // one front-side request from valid to ready
   task automatic run_request(input logic is_write, input logic [3:0] sel,
                              input logic [1:0] word, input cache_pkg::data_t data,
                              input cache_pkg::strb_t strb);
      logic [7:0]       line;
      logic [5:0]       idx;
      cache_pkg::addr_t a;
      logic             resident;
      int               ar_before;
      int               wait_cycles;
      line        = {sel[3], 2'b00, sel[2:0], 2'b00};
      idx         = line[5:0];
      a           = {20'd0, line, word, 2'b00};
      resident    = resident_valid[idx] && (resident_line[idx] == line);
      ar_before   = ar_count;
      wait_cycles = 0;
      valid       = 1'b1;
      addr        = a;
      wdata       = data;
      wstrb       = is_write ? strb : '0;
      do
      begin
         @(posedge clk);
         wait_cycles++;
      end
      while (!ready);
      if (is_write)
      begin
         for (int i = 0; i < cache_pkg::nbytes; i++)
         begin
            if (strb[i])
               shadow[a[11:2]][8*i +: 8] = data[8*i +: 8];
         end
         exp_addr_q.push_back(a);
         exp_data_q.push_back(data);
         exp_strb_q.push_back(strb);
      end
      else
      begin
         check(rdata, shadow[a[11:2]], "read data");
         if (resident)
         begin
            check(32'(ar_count - ar_before), 32'd0, "AR count of a read hit");
            check(32'(wait_cycles), 32'd2, "read hit latency");
         end
         else
         begin
            check(32'(ar_count - ar_before), 32'd1, "AR count of a read miss");
            check(last_araddr, {a[31:4], 4'b0000}, "line fill address");
            // write misses never get here, so they stay non-resident
            resident_valid[idx] = 1'b1;
            resident_line[idx]  = line;
         end
      end
      #1;
      valid = 1'b0;
   endtask

   initial
   begin
      logic [31:0]      r;
      logic             is_write;
      cache_pkg::strb_t strb;
      int               gap;
      void'($urandom(32'h3c6b_6fb8));
      rst_n = 1'b0;
      valid = 1'b0;
      addr  = '0;
      wdata = '0;
      wstrb = '0;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int i = 0; i < 1024; i++)
         shadow[i] = i_mem.mem[i];
      for (int i = 0; i < 64; i++)
      begin
         resident_valid[i] = 1'b0;
         resident_line[i]  = '0;
      end

      // quiet bus before the first request
      repeat (4)
      begin
         @(posedge clk);
         check(32'({ready, axi_arvalid, axi_awvalid, axi_wvalid, axi_rready, axi_bready}),
               32'd0, "ready, AXI valid or AXI ready high before the first request");
      end
      #1;

      for (int n = 0; n < n_req; n++)
      begin
         r = $urandom;
         // runs of writes then reads every 50 requests, random otherwise
         if (n % 50 < 6)
            is_write = 1'b1;
         else if (n % 50 < 12)
            is_write = 1'b0;
         else
            is_write = r[0];
         strb = (r[7:4] == 4'h0) ? 4'hf : r[7:4];
         run_request(is_write, r[11:8], r[13:12], $urandom, strb);
         gap = (r[17:16] == 2'b00) ? int'(r[19:18]) : 0;
         repeat (gap)
         begin
            @(posedge clk);
            #1;
         end
      end

      // let the buffer drain before comparing memories
      while (exp_rd < exp_addr_q.size())
         @(posedge clk);
      repeat (4) @(posedge clk);
      check(32'(aw_q.size() + w_data_q.size()), 32'd0, "unmatched AW or W transfers");
      for (int i = 0; i < 1024; i++)
         check(i_mem.mem[i], shadow[i], "memory word after drain");
      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- cache_axi.f
hdl/cache_pkg.sv
hdl/cache_memory.sv
hdl/write_through_buffer.sv
hdl/back_end_axi.sv
hdl/cache_axi.sv
testbench/axi_mem_model.sv
testbench/tb_cache_axi.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
verilator --binary -j 0 --top-module tb_cache_axi -f cache_axi.f \
   || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/Vtb_cache_axi)
echo "$out"
echo "$out" | grep -q "Testbench passed" \
   && echo "simulation ok" \
   || { echo "simulation did not pass"; exit 1; }
